// ==== hw/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [1:0]  mem_size_t;   // Encoding of the SIZE bus

    localparam word_t reset_pc  = 32'h0001_0000;
    localparam word_t nop_instr = 32'h0000_0013;   // addi x0,x0,0

    localparam mem_size_t size_byte = 2'b00;
    localparam mem_size_t size_half = 2'b01;
    localparam mem_size_t size_word = 2'b10;

    // RV32I major opcodes
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_branch = 7'b1100011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sll,
        alu_srl,
        alu_sra,
        alu_slt,
        alu_sltu
    } alu_op_t;

    typedef enum logic [1:0] {fwd_none, fwd_ex, fwd_mem} fwd_sel_t;

endpackage

`default_nettype wire

// ==== hw/rv_pipe_if.sv ====
`default_nettype none

interface idex_if import rv_pkg::*; ();
    logic      valid;
    word_t     pc;
    word_t     pc4;
    word_t     op1;   // Already forwarded
    word_t     op2;
    word_t     imm;
    alu_op_t   alu_op;
    opcode_t   opcode;
    funct3_t   funct3;
    reg_addr_t rd;
    logic      wr_en;

    modport decode (
        output valid, pc, pc4, op1, op2, imm, alu_op, opcode, funct3, rd, wr_en
    );
    modport execute (
        input valid, pc, pc4, op1, op2, imm, alu_op, opcode, funct3, rd, wr_en
    );
endinterface

interface exmem_if import rv_pkg::*; ();
    logic      valid;
    word_t     pc4;
    word_t     result;       // ALU result, also the data address
    word_t     store_data;
    funct3_t   funct3;
    opcode_t   opcode;
    reg_addr_t rd;
    logic      wr_en;

    modport execute (
        output valid, pc4, result, store_data, funct3, opcode, rd, wr_en
    );
    modport memory (
        input valid, pc4, result, store_data, funct3, opcode, rd, wr_en
    );
endinterface

`default_nettype wire

// ==== hw/fetch_stage.sv ====
`default_nettype none

module fetch_stage import rv_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  acki_n,
    input  logic  mem_stall,
    input  logic  redirect,
    input  word_t target,
    input  word_t idt,
    output word_t iad,
    output logic  hold,
    output logic  flush,
    output word_t if_pc,
    output word_t if_pc4,
    output word_t if_instr,
    output logic  if_valid
);

    word_t pc;
    word_t pc4;

    assign pc4   = pc + 32'd4;
    assign iad   = pc;
    assign hold  = acki_n | mem_stall;   // Wait state on either bus
    assign flush = redirect;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= reset_pc;
        end else if (!hold) begin
            pc <= redirect ? target : pc4;
        end
    end

    // IF/ID register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            if_valid <= 1'b0;
            if_instr <= nop_instr;
        end else if (!hold) begin
            if_valid <= !flush;
            if_instr <= flush ? nop_instr : idt;   // Bubble on redirect
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            if_pc  <= pc;
            if_pc4 <= pc4;
        end
    end

endmodule

`default_nettype wire

// ==== hw/decode_stage.sv ====
`default_nettype none

module decode_stage import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      hold,
    input  logic      flush,
    input  word_t     if_pc,
    input  word_t     if_pc4,
    input  word_t     if_instr,
    input  logic      if_valid,
    output reg_addr_t rs1,
    output reg_addr_t rs2,
    input  word_t     rf_data1,
    input  word_t     rf_data2,
    input  fwd_sel_t  fwd1,
    input  fwd_sel_t  fwd2,
    input  word_t     ex_fwd_data,
    input  word_t     mem_fwd_data,
    idex_if.decode    idex
);

    opcode_t    opcode;
    reg_addr_t  rd;
    funct3_t    funct3;
    logic [6:0] funct7;
    word_t      imm;
    alu_op_t    alu_op;
    logic       wr_en;
    word_t      op1;
    word_t      op2;

    assign opcode = opcode_t'(if_instr[6:0]);
    assign rd     = if_instr[11:7];
    assign funct3 = if_instr[14:12];
    assign rs1    = if_instr[19:15];
    assign rs2    = if_instr[24:20];
    assign funct7 = if_instr[31:25];

    always_comb begin
        case (opcode)
            opc_store:          imm = {{20{if_instr[31]}}, if_instr[31:25], if_instr[11:7]};
            opc_branch:         imm = {{19{if_instr[31]}}, if_instr[31], if_instr[7],
                                       if_instr[30:25], if_instr[11:8], 1'b0};
            opc_lui, opc_auipc: imm = {if_instr[31:12], 12'b0};
            opc_jal:            imm = {{11{if_instr[31]}}, if_instr[31], if_instr[19:12],
                                       if_instr[20], if_instr[30:21], 1'b0};
            default:            imm = {{20{if_instr[31]}}, if_instr[31:20]};   // I-type
        endcase
    end

    // Everything that is not op/op_imm computes an address or a sum
    always_comb begin
        alu_op = alu_add;
        if (opcode == opc_op || opcode == opc_op_imm) begin
            case (funct3)
                3'b000:  alu_op = (opcode == opc_op && funct7[5]) ? alu_sub : alu_add;
                3'b001:  alu_op = alu_sll;
                3'b010:  alu_op = alu_slt;
                3'b011:  alu_op = alu_sltu;
                3'b100:  alu_op = alu_xor;
                3'b101:  alu_op = funct7[5] ? alu_sra : alu_srl;
                3'b110:  alu_op = alu_or;
                default: alu_op = alu_and;
            endcase
        end
    end

    always_comb begin
        case (opcode)
            opc_op, opc_op_imm, opc_lui, opc_auipc, opc_jal, opc_jalr, opc_load:
                wr_en = (rd != '0);
            default: wr_en = 1'b0;   // Branch, store, unknown
        endcase
    end

    always_comb begin
        case (fwd1)
            fwd_ex:  op1 = ex_fwd_data;
            fwd_mem: op1 = mem_fwd_data;
            default: op1 = rf_data1;
        endcase
        case (fwd2)
            fwd_ex:  op2 = ex_fwd_data;
            fwd_mem: op2 = mem_fwd_data;
            default: op2 = rf_data2;
        endcase
    end

    // ID/EX register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            idex.valid <= 1'b0;
            idex.wr_en <= 1'b0;
        end else if (!hold) begin
            idex.valid <= if_valid && !flush;
            idex.wr_en <= if_valid && !flush && wr_en;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            idex.pc     <= if_pc;
            idex.pc4    <= if_pc4;
            idex.op1    <= op1;
            idex.op2    <= op2;
            idex.imm    <= imm;
            idex.alu_op <= alu_op;
            idex.opcode <= opcode;
            idex.funct3 <= funct3;
            idex.rd     <= rd;
        end
    end

endmodule

`default_nettype wire

// ==== hw/reg_file.sv ====
`default_nettype none

module reg_file import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      wr_en,
    input  reg_addr_t wr_addr,
    input  word_t     wr_data,
    input  reg_addr_t rd1_addr,
    input  reg_addr_t rd2_addr,
    output word_t     rd1_data,
    output word_t     rd2_data
);

    word_t regs [32];

    // x0 reads zero, a same-cycle write is passed through
    function automatic word_t read_port(reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (wr_en && addr == wr_addr) begin
            return wr_data;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk) begin
        if (rst_n && wr_en && wr_addr != '0) begin   // No writes in reset
            regs[wr_addr] <= wr_data;
        end
    end

    always_comb begin
        rd1_data = read_port(rd1_addr);
        rd2_data = read_port(rd2_addr);
    end

endmodule

`default_nettype wire

// ==== hw/forward_unit.sv ====
`default_nettype none

module forward_unit import rv_pkg::*; (
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    input  reg_addr_t ex_rd,
    input  logic      ex_wr_en,
    input  reg_addr_t mem_rd,
    input  logic      mem_wr_en,
    output fwd_sel_t  fwd1,
    output fwd_sel_t  fwd2
);

    // The youngest producer wins
    function automatic fwd_sel_t pick(reg_addr_t rs);
        logic hit_ex;
        logic hit_mem;
        hit_ex  = ex_wr_en && (ex_rd != '0) && (ex_rd == rs);
        hit_mem = mem_wr_en && (mem_rd != '0) && (mem_rd == rs);
        if (hit_ex) begin
            return fwd_ex;
        end
        if (hit_mem) begin
            return fwd_mem;
        end
        return fwd_none;   // Register file value
    endfunction

    always_comb begin
        fwd1 = pick(rs1);
        fwd2 = pick(rs2);
    end

endmodule

`default_nettype wire

// ==== hw/execute_stage.sv ====
`default_nettype none

module execute_stage import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      hold,
    idex_if.execute   idex,
    exmem_if.execute  exmem,
    output logic      redirect,
    output word_t     target,
    output word_t     ex_fwd_data,
    output reg_addr_t ex_rd,
    output logic      ex_wr_en
);

    word_t alu_a;
    word_t alu_b;
    word_t alu_y;
    logic  is_jump;
    logic  taken;

    assign is_jump = (idex.opcode == opc_jal) || (idex.opcode == opc_jalr);

    always_comb begin
        case (idex.opcode)
            opc_auipc: alu_a = idex.pc;
            opc_lui:   alu_a = '0;   // lui is imm + 0
            default:   alu_a = idex.op1;
        endcase
    end

    assign alu_b = (idex.opcode == opc_op) ? idex.op2 : idex.imm;

    always_comb begin
        case (idex.alu_op)
            alu_add:  alu_y = alu_a + alu_b;
            alu_sub:  alu_y = alu_a - alu_b;
            alu_sll:  alu_y = alu_a << alu_b[4:0];
            alu_srl:  alu_y = alu_a >> alu_b[4:0];
            alu_sra:  alu_y = $signed(alu_a) >>> alu_b[4:0];
            alu_slt:  alu_y = {31'b0, $signed(alu_a) < $signed(alu_b)};
            alu_sltu: alu_y = {31'b0, alu_a < alu_b};
            alu_xor:  alu_y = alu_a ^ alu_b;
            alu_or:   alu_y = alu_a | alu_b;
            default:  alu_y = alu_a & alu_b;
        endcase
    end

    always_comb begin
        case (idex.funct3)
            3'b000:  taken = (idex.op1 == idex.op2);
            3'b001:  taken = (idex.op1 != idex.op2);
            3'b100:  taken = $signed(idex.op1) < $signed(idex.op2);
            3'b101:  taken = $signed(idex.op1) >= $signed(idex.op2);
            3'b110:  taken = idex.op1 < idex.op2;
            default: taken = idex.op1 >= idex.op2;   // bgeu
        endcase
    end

    // jalr target comes out of the ALU as rs1 + imm
    assign target   = (idex.opcode == opc_jalr) ? {alu_y[31:1], 1'b0} : idex.pc + idex.imm;
    assign redirect = idex.valid && (is_jump || (idex.opcode == opc_branch && taken));

    assign ex_fwd_data = is_jump ? idex.pc4 : alu_y;
    assign ex_rd       = idex.rd;
    assign ex_wr_en    = idex.wr_en;

    // EX/MEM register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exmem.valid <= 1'b0;
            exmem.wr_en <= 1'b0;
        end else if (!hold) begin
            exmem.valid <= idex.valid;
            exmem.wr_en <= idex.wr_en;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            exmem.pc4        <= idex.pc4;
            exmem.result     <= alu_y;
            exmem.store_data <= idex.op2;
            exmem.funct3     <= idex.funct3;
            exmem.opcode     <= idex.opcode;
            exmem.rd         <= idex.rd;
        end
    end

endmodule

`default_nettype wire

// ==== hw/memory_stage.sv ====
`default_nettype none

module memory_stage import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      hold,
    exmem_if.memory   exmem,
    input  logic      ackd_n,
    input  word_t     rdata,
    output word_t     dad,
    output word_t     wdata,
    output logic      mreq,
    output logic      write,
    output mem_size_t size,
    output logic      mem_stall,
    output word_t     mem_fwd_data,
    output reg_addr_t mem_rd,
    output logic      mem_wr_en,
    output logic      wb_en,
    output reg_addr_t wb_addr,
    output word_t     wb_data
);

    logic  is_load;
    logic  is_store;
    word_t shifted;
    word_t load_data;

    assign is_load  = exmem.valid && (exmem.opcode == opc_load);
    assign is_store = exmem.valid && (exmem.opcode == opc_store);

    assign mreq      = is_load || is_store;
    assign write     = is_store;
    assign dad       = exmem.result;
    assign size      = exmem.funct3[1:0];   // funct3 low bits match SIZE
    assign mem_stall = mreq && ackd_n;      // Until ACKD_n goes low

    // Store data on every lane, the address picks the bytes
    always_comb begin
        case (size)
            size_byte: wdata = {4{exmem.store_data[7:0]}};
            size_half: wdata = {2{exmem.store_data[15:0]}};
            default:   wdata = exmem.store_data;
        endcase
    end

    assign shifted = rdata >> {exmem.result[1:0], 3'b000};

    always_comb begin
        case (exmem.funct3)
            3'b000:  load_data = {{24{shifted[7]}}, shifted[7:0]};     // lb
            3'b100:  load_data = {24'b0, shifted[7:0]};
            3'b001:  load_data = {{16{shifted[15]}}, shifted[15:0]};   // lh
            3'b101:  load_data = {16'b0, shifted[15:0]};
            default: load_data = shifted;
        endcase
    end

    always_comb begin
        case (exmem.opcode)
            opc_load:          mem_fwd_data = load_data;
            opc_jal, opc_jalr: mem_fwd_data = exmem.pc4;   // Link address
            default:           mem_fwd_data = exmem.result;
        endcase
    end

    assign mem_rd    = exmem.rd;
    assign mem_wr_en = exmem.wr_en;

    // MEM/WB register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_en <= 1'b0;
        end else if (!hold) begin
            wb_en <= exmem.wr_en;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            wb_addr <= exmem.rd;
            wb_data <= mem_fwd_data;
        end
    end

endmodule

`default_nettype wire

// ==== hw/rv_core_top.sv ====
`default_nettype none

module rv_core_top import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    output word_t     iad,      // Instruction address
    input  word_t     idt,
    input  logic      acki_n,   // Low when idt is valid
    output word_t     dad,
    input  word_t     rdata,
    output word_t     wdata,
    output logic      mreq,
    output logic      write,
    output mem_size_t size,
    input  logic      ackd_n    // Low ends the data transfer
);

    logic      hold;
    logic      flush;
    logic      redirect;
    logic      mem_stall;
    word_t     target;
    word_t     if_pc;
    word_t     if_pc4;
    word_t     if_instr;
    logic      if_valid;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     rf_data1;
    word_t     rf_data2;
    fwd_sel_t  fwd1;
    fwd_sel_t  fwd2;
    word_t     ex_fwd_data;
    reg_addr_t ex_rd;
    logic      ex_wr_en;
    word_t     mem_fwd_data;
    reg_addr_t mem_rd;
    logic      mem_wr_en;
    logic      wb_en;
    reg_addr_t wb_addr;
    word_t     wb_data;

    idex_if  idex ();
    exmem_if exmem ();

    fetch_stage fetch_stage_inst (.*);

    decode_stage decode_stage_inst (.*);

    reg_file reg_file_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (wb_en),
        .wr_addr  (wb_addr),
        .wr_data  (wb_data),
        .rd1_addr (rs1),
        .rd2_addr (rs2),
        .rd1_data (rf_data1),
        .rd2_data (rf_data2)
    );

    forward_unit forward_unit_inst (.*);

    execute_stage execute_stage_inst (.*);

    memory_stage memory_stage_inst (.*);

endmodule

`default_nettype wire

// ==== verif/rv_mem_model.sv ====
`default_nettype none

module rv_mem_model import rv_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      wait_en,
    input  word_t     iad,
    output word_t     idt,
    output logic      acki_n,
    input  word_t     dad,
    output word_t     rdata,
    input  word_t     wdata,
    input  logic      mreq,
    input  logic      write,
    input  mem_size_t size,
    output logic      ackd_n
);

    timeunit 1ns;
    timeprecision 1ps;

    word_t       imem [64];    // Program at reset_pc
    word_t       dmem [256];   // 1 KB data at address 0
    int unsigned iwait;
    int unsigned dwait;
    int          log_count;
    word_t       log_addr [16];
    mem_size_t   log_size [16];
    word_t       log_data [16];
    word_t       ioff;
    logic [3:0]  lanes;

    function automatic int unsigned pick_wait();
        if (wait_en) begin
            return $urandom % 3;
        end
        return 0;
    endfunction

    function automatic logic [3:0] lane_en(mem_size_t sz, logic [1:0] lo);
        case (sz)
            size_byte: return 4'b0001 << lo;
            size_half: return lo[1] ? 4'b1100 : 4'b0011;
            default:   return 4'b1111;
        endcase
    endfunction

    assign ioff   = iad - reset_pc;
    assign idt    = (ioff < 32'd256) ? imem[ioff[7:2]] : nop_instr;
    assign rdata  = (dad < 32'h400) ? dmem[dad[9:2]] : '0;
    assign acki_n = (iwait != 0);
    assign ackd_n = !(mreq && dwait == 0);
    assign lanes  = lane_en(size, dad[1:0]);

    always @(posedge clk) begin
        if (!rst_n) begin
            iwait     <= 0;
            dwait     <= 0;
            log_count <= 0;
        end else begin
            iwait <= (iwait != 0) ? iwait - 1 : pick_wait();   // New wait after each ack
            if (mreq) begin
                if (dwait != 0) begin
                    dwait <= dwait - 1;
                end else begin
                    dwait <= pick_wait();
                    if (write) begin
                        for (int l = 0; l < 4; l++) begin
                            if (lanes[l] && dad < 32'h400) begin
                                dmem[dad[9:2]][8*l +: 8] <= wdata[8*l +: 8];
                            end
                        end
                        if (log_count < 16) begin
                            log_addr[log_count] <= dad;
                            log_size[log_count] <= size;
                            log_data[log_count] <= wdata;
                        end
                        log_count <= log_count + 1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verif/rv_core_tb.sv ====
`default_nettype none

module rv_core_tb import rv_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    typedef enum int {
        op_add, op_sub, op_and, op_or, op_xor, op_sll, op_srl, op_sra, op_slt, op_sltu,
        op_addi, op_slti, op_sltiu, op_xori, op_ori, op_andi, op_slli, op_srli, op_srai,
        op_lui, op_auipc, op_lb, op_lbu, op_lh, op_lhu, op_lw,
        op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu, op_jal, op_jalr
    } test_op_t;

    typedef struct {
        test_op_t op;
        word_t    a;
        word_t    b;
        logic     wait_en;
        word_t    expected;
    } row_t;

    localparam word_t result_addr = 32'h0000_03f0;

    logic      clk;
    logic      rst_n;
    logic      wait_en;
    word_t     iad;
    word_t     idt;
    logic      acki_n;
    word_t     dad;
    word_t     rdata;
    word_t     wdata;
    logic      mreq;
    logic      write;
    mem_size_t size;
    logic      ackd_n;

    row_t rows [100];
    int   num_rows;
    int   errors;
    int   passed;
    int   cycles;
    int   cycle_limit;

    rv_core_top rv_core_top_inst (.*);

    rv_mem_model mem_model_inst (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Watchdog sized from the table
    initial begin
        cycles = 0;
        while (cycle_limit == 0 || cycles <= cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Cycle limit of %0d reached before all rows finished", cycle_limit);
        $display("Test failed");
        $finish;
    end

    function automatic word_t r_instr(logic [9:0] f73, reg_addr_t rs2, reg_addr_t rs1,
                                      reg_addr_t rd);
        return {f73[9:3], rs2, rs1, f73[2:0], rd, opc_op};
    endfunction

    function automatic word_t i_instr(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                      reg_addr_t rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t s_instr(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                      logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opc_store};
    endfunction

    function automatic word_t b_instr(logic [12:0] off, reg_addr_t rs2, reg_addr_t rs1,
                                      logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opc_branch};
    endfunction

    function automatic word_t j_instr(logic [20:0] off, reg_addr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, opc_jal};
    endfunction

    // funct7 and funct3 of the R-type and I-type ALU forms
    function automatic logic [9:0] alu_funct(test_op_t op);
        case (op)
            op_sub:             return {7'b0100000, 3'b000};
            op_sll, op_slli:    return {7'b0, 3'b001};
            op_slt, op_slti:    return {7'b0, 3'b010};
            op_sltu, op_sltiu:  return {7'b0, 3'b011};
            op_xor, op_xori:    return {7'b0, 3'b100};
            op_srl, op_srli:    return {7'b0, 3'b101};
            op_sra, op_srai:    return {7'b0100000, 3'b101};
            op_or, op_ori:      return {7'b0, 3'b110};
            op_and, op_andi:    return {7'b0, 3'b111};
            default:            return {7'b0, 3'b000};
        endcase
    endfunction

    function automatic logic [2:0] branch_f3(test_op_t op);
        case (op)
            op_beq:  return 3'b000;
            op_bne:  return 3'b001;
            op_blt:  return 3'b100;
            op_bge:  return 3'b101;
            op_bltu: return 3'b110;
            default: return 3'b111;
        endcase
    endfunction

    function automatic logic [2:0] mem_f3(test_op_t op);
        case (op)
            op_lb:   return 3'b000;
            op_lh:   return 3'b001;
            op_lbu:  return 3'b100;
            op_lhu:  return 3'b101;
            default: return 3'b010;
        endcase
    endfunction

    // Byte offset of the load/store test inside its word
    function automatic logic [1:0] mem_off(test_op_t op, word_t b);
        case (op)
            op_lb, op_lbu: return b[1:0];
            op_lh, op_lhu: return {b[1], 1'b0};
            default:       return 2'b00;
        endcase
    endfunction

    function automatic word_t isa_result(test_op_t op, word_t a, word_t b);
        word_t imm;
        imm = {{20{b[11]}}, b[11:0]};
        case (op)
            op_add:   return a + b;
            op_sub:   return a - b;
            op_and:   return a & b;
            op_or:    return a | b;
            op_xor:   return a ^ b;
            op_sll:   return a << b[4:0];
            op_srl:   return a >> b[4:0];
            op_sra:   return $signed(a) >>> b[4:0];
            op_slt:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            op_sltu:  return (a < b) ? 32'd1 : 32'd0;
            op_addi:  return a + imm;
            op_slti:  return ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0;
            op_sltiu: return (a < imm) ? 32'd1 : 32'd0;
            op_xori:  return a ^ imm;
            op_ori:   return a | imm;
            op_andi:  return a & imm;
            op_slli:  return a << b[4:0];
            op_srli:  return a >> b[4:0];
            op_srai:  return $signed(a) >>> b[4:0];
            op_lui:   return {b[31:12], 12'b0};
            op_auipc: return reset_pc + 32'd16 + {b[31:12], 12'b0};
            op_lb:    return {{24{a[7]}}, a[7:0]};
            op_lbu:   return {24'b0, a[7:0]};
            op_lh:    return {{16{a[15]}}, a[15:0]};
            op_lhu:   return {16'b0, a[15:0]};
            op_lw:    return a;
            op_beq:   return (a == b) ? 32'd5 : 32'd7;   // 5 when the addi is skipped
            op_bne:   return (a != b) ? 32'd5 : 32'd7;
            op_blt:   return ($signed(a) < $signed(b)) ? 32'd5 : 32'd7;
            op_bge:   return ($signed(a) >= $signed(b)) ? 32'd5 : 32'd7;
            op_bltu:  return (a < b) ? 32'd5 : 32'd7;
            op_bgeu:  return (a >= b) ? 32'd5 : 32'd7;
            op_jal:   return reset_pc + 32'd20;
            default:  return reset_pc + 32'd24;   // jalr link
        endcase
    endfunction

    task automatic add_row(test_op_t op, word_t a, word_t b, logic w);
        rows[num_rows].op       = op;
        rows[num_rows].a        = a;
        rows[num_rows].b        = b;
        rows[num_rows].wait_en  = w;
        rows[num_rows].expected = isa_result(op, a, b);
        num_rows++;
    endtask

    task automatic load_program(row_t r);
        word_t       prog [$];
        logic [11:0] addr;
        logic [9:0]  f73;
        logic [2:0]  mf3;
        word_t       a_hi;
        word_t       b_hi;
        a_hi = r.a + 32'h800;   // addi sign-extends its low 12 bits
        b_hi = r.b + 32'h800;
        addr = 12'h100 + mem_off(r.op, r.b);
        f73  = alu_funct(r.op);
        mf3  = mem_f3(r.op);
        prog.push_back({a_hi[31:12], 5'd1, opc_lui});
        prog.push_back({b_hi[31:12], 5'd2, opc_lui});
        prog.push_back(i_instr(r.a[11:0], 5'd1, 3'b000, 5'd1, opc_op_imm));
        prog.push_back(i_instr(r.b[11:0], 5'd2, 3'b000, 5'd2, opc_op_imm));
        if (r.op <= op_sltu) begin
            prog.push_back(r_instr(f73, 5'd2, 5'd1, 5'd3));
        end else if (r.op <= op_srai) begin
            if (r.op == op_slli || r.op == op_srli || r.op == op_srai) begin
                prog.push_back(i_instr({f73[9:3], r.b[4:0]}, 5'd1, f73[2:0], 5'd3,
                                       opc_op_imm));
            end else begin
                prog.push_back(i_instr(r.b[11:0], 5'd1, f73[2:0], 5'd3, opc_op_imm));
            end
        end else if (r.op == op_lui || r.op == op_auipc) begin
            prog.push_back({r.b[31:12], 5'd3, (r.op == op_lui) ? opc_lui : opc_auipc});
        end else if (r.op <= op_lw) begin
            prog.push_back(s_instr(addr, 5'd1, 5'd0, {1'b0, mf3[1:0]}));
            prog.push_back(nop_instr);
            prog.push_back(i_instr(addr, 5'd0, mf3, 5'd3, opc_load));
            prog.push_back(nop_instr);   // Load-use gap
        end else if (r.op <= op_bgeu) begin
            prog.push_back(i_instr(12'd5, 5'd0, 3'b000, 5'd3, opc_op_imm));
            prog.push_back(b_instr(13'd8, 5'd2, 5'd1, branch_f3(r.op)));
            prog.push_back(i_instr(12'd7, 5'd0, 3'b000, 5'd3, opc_op_imm));
        end else if (r.op == op_jal) begin
            prog.push_back(j_instr(21'd8, 5'd3));
            prog.push_back(i_instr(12'd7, 5'd0, 3'b000, 5'd3, opc_op_imm));
        end else begin
            prog.push_back({20'b0, 5'd4, opc_auipc});
            prog.push_back(i_instr(12'd13, 5'd4, 3'b000, 5'd3, opc_jalr));   // Odd offset, bit 0 dropped
            prog.push_back(i_instr(12'd7, 5'd0, 3'b000, 5'd3, opc_op_imm));
        end
        prog.push_back(s_instr(result_addr[11:0], 5'd3, 5'd0, 3'b010));
        prog.push_back(j_instr(21'd0, 5'd0));
        for (int i = 0; i < 64; i++) begin
            mem_model_inst.imem[i] = (i < prog.size()) ? prog[i] : nop_instr;
        end
        for (int i = 0; i < 256; i++) begin
            mem_model_inst.dmem[i] = 32'h5a00_0000 ^ (i * 32'h0001_0203);
        end
    endtask

    function automatic int find_result();
        for (int i = 0; i < mem_model_inst.log_count && i < 16; i++) begin
            if (mem_model_inst.log_addr[i] == result_addr) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic check_store(int row, row_t r, output int bad);
        word_t       got;
        logic [1:0]  off;
        logic [2:0]  f3;
        logic [1:0]  sz;
        bad = 0;
        off = mem_off(r.op, r.b);
        f3  = mem_f3(r.op);
        sz  = f3[1:0];
        if (mem_model_inst.log_addr[0] != 32'h100 + off) begin
            $display("MISMATCH row %0d dad: expected %h got %h", row, 32'h100 + off,
                     mem_model_inst.log_addr[0]);
            bad++;
        end
        if (mem_model_inst.log_size[0] != sz) begin
            $display("MISMATCH row %0d size: expected %h got %h", row, sz,
                     mem_model_inst.log_size[0]);
            bad++;
        end
        got = mem_model_inst.log_data[0];
        if ((sz == 2'b00 && got[8*off +: 8] != r.a[7:0]) ||
            (sz == 2'b01 && got[8*off +: 16] != r.a[15:0]) ||
            (sz == 2'b10 && got != r.a)) begin
            $display("MISMATCH row %0d wdata lanes: a %h got %h", row, r.a, got);
            bad++;
        end
    endtask

    initial begin
        int    idx;
        int    bad;
        int    base_rows;
        word_t got;
        word_t a;
        word_t b;
        rst_n       = 1'b0;
        wait_en     = 1'b0;
        num_rows    = 0;
        errors      = 0;
        passed      = 0;
        cycle_limit = 0;
        void'($urandom(32'ha864_50c8));
        for (int i = 0; i <= int'(op_jalr); i++) begin
            a = $urandom;
            b = $urandom;
            add_row(test_op_t'(i), a, b, 1'b0);
            if (test_op_t'(i) >= op_beq && test_op_t'(i) <= op_bgeu) begin
                add_row(test_op_t'(i), b, a, 1'b0);   // Swapped operands
                add_row(test_op_t'(i), a, a, 1'b0);   // Equal operands
            end
        end
        base_rows = num_rows;
        for (int i = 0; i < base_rows; i++) begin
            add_row(rows[i].op, rows[i].a, rows[i].b, 1'b1);   // Same rows with wait states
        end
        cycle_limit = num_rows * (40 * 3 + 16);

        for (int r = 0; r < num_rows; r++) begin
            @(posedge clk);
            #2;
            rst_n   = 1'b0;
            wait_en = rows[r].wait_en;
            load_program(rows[r]);
            repeat (16) @(posedge clk);
            #2;
            rst_n = 1'b1;
            idx = -1;
            while (idx < 0) begin
                @(posedge clk);
                #1;
                idx = find_result();
            end
            bad = 0;
            got = mem_model_inst.log_data[idx];
            if (got != rows[r].expected) begin
                $display("MISMATCH row %0d result: expected %h got %h", r,
                         rows[r].expected, got);
                bad++;
            end
            if (rows[r].op >= op_lb && rows[r].op <= op_lw) begin
                check_store(r, rows[r], idx);
                bad += idx;
            end
            errors += bad;
            if (bad == 0) begin
                passed++;
            end
            $display("row %0d %s a=%h b=%h wait=%0d: %s", r, rows[r].op.name(), rows[r].a,
                     rows[r].b, rows[r].wait_en, (bad == 0) ? "ok" : "FAILED");
        end

        $display("%0d rows run, %0d passed, %0d checks failed", num_rows, passed, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
hw/rv_pkg.sv
hw/rv_pipe_if.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/reg_file.sv
hw/forward_unit.sv
hw/execute_stage.sv
hw/memory_stage.sv
hw/rv_core_top.sv
verif/rv_mem_model.sv
verif/rv_core_tb.sv
